/* ring_shell.f */
+incdir+.
ring_pkg.sv
ring_slot_gen.sv
ring_injector.sv
ring_extractor.sv
ring_sink.sv
ring_shell.sv
tb_ring_shell.sv

/* run.sh */
#!/bin/sh
# build and run the ring shell testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ring_shell -f ring_shell.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_ring_shell)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "No errors"; then
    exit 0
fi
echo "simulation reported failures"
exit 1

/* tb_ring_tasks.svh */
// compare, wait and test tasks of the ring shell testbench
// included inside tb_ring_shell after its signal declarations
`ifndef TB_RING_TASKS_SVH
`define TB_RING_TASKS_SVH

typedef enum int {
    UNTIL_RX,
    UNTIL_SENT,
    UNTIL_DROP,
    UNTIL_OWED_CLEAR
} until_t;

// ======================================================================
// compare tasks
// ======================================================================
task automatic check_word(input string name, input word_t got, input word_t exp);
    checks += 1;
    if (got !== exp)
    begin
        errors += 1;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_count(input string name, input drop_cnt_t got, input drop_cnt_t exp);
    checks += 1;
    if (got !== exp)
    begin
        errors += 1;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    checks += 1;
    if (got !== exp)
    begin
        errors += 1;
        $display("MISMATCH %s: got %h, expected %h", name, got, exp);
    end
endtask

// ======================================================================
// queue helpers and waits
// ======================================================================
function automatic int rx_size(input int port);
    return (port == 0) ? rx0_q.size() : rx1_q.size();
endfunction

function automatic stream_t rx_pop(input int port);
    if (port == 0)
        return rx0_q.pop_front();
    return rx1_q.pop_front();
endfunction

function automatic int exp_size(input int br);
    return (br == 0) ? exp_br0_q.size() : exp_br1_q.size();
endfunction

function automatic word_t exp_pop(input int br);
    if (br == 0)
        return exp_br0_q.pop_front();
    return exp_br1_q.pop_front();
endfunction

function automatic bit reached(input until_t what, input int idx, input int target);
    case (what)
        UNTIL_RX:   return rx_size(idx) >= target;
        UNTIL_SENT: return ((idx == 0) ? br0_q.size() : br1_q.size()) == 0;
        UNTIL_DROP: return int'(drop_sampled) >= target;
        default:    return mem_owed[idx] == 0;
    endcase
endfunction

task automatic wait_until(input until_t what, input int idx, input int target, output bit ok);
    int cyc;
    cyc = 0;
    while (!reached(what, idx, target) && cyc < WAIT_CYC)
    begin
        @(posedge clk);
        cyc += 1;
    end
    ok = reached(what, idx, target);
    if (!ok)
    begin
        errors += 1;
        $display("timeout after %0d cycles waiting for %s, index %0d, target %0d",
                 WAIT_CYC, what.name(), idx, target);
    end
endtask

// four words from one branch with random payload
task automatic queue_frame(input int br, input addr_t addr, input bit expected);
    logic [95:0] rnd;
    stream_t     s;
    for (int i = 0; i < FRAME_WORDS; i++)
    begin
        rnd   = {$urandom(), $urandom(), $urandom()};
        s.stb = 1'b1;
        s.sof = (i == 0);
        if (i == 0)
            s.data = {br[0], rnd[31:0], addr};
        else
            s.data = rnd[WORD_W-1:0];
        if (br == 0)
        begin
            br0_q.push_back(s);
            if (expected)
                exp_br0_q.push_back(s.data);
        end
        else
        begin
            br1_q.push_back(s);
            if (expected)
                exp_br1_q.push_back(s.data);
        end
    end
endtask

// waits for whole frames on a port and checks them against their branch
task automatic take_frames(input int port, input int n_frames);
    stream_t w;
    int      br;
    bit      ok;
    br = 0;
    for (int f = 0; f < n_frames; f++)
    begin
        wait_until(UNTIL_RX, port, FRAME_WORDS, ok);
        if (!ok)
            return;
        for (int i = 0; i < FRAME_WORDS; i++)
        begin
            w = rx_pop(port);
            if (i == 0)
                br = int'(w.data[WORD_W-1]);
            if (exp_size(br) == 0)
            begin
                errors += 1;
                $display("unexpected word on mem%0d, branch %0d had no frame outstanding",
                         port, br);
                return;
            end
            check_word($sformatf("mem%0d.data", port), w.data, exp_pop(br));
            check_bit($sformatf("mem%0d.sof", port), w.sof, (i == 0));
        end
    end
endtask

task automatic finish_test(input string name, input int err0);
    tests_run += 1;
    if (errors == err0)
        $display("test %0d %s: pass", tests_run, name);
    else
    begin
        tests_failed += 1;
        $display("test %0d %s: FAIL with %0d errors", tests_run, name, errors - err0);
    end
endtask

// ======================================================================
// directed tests
// ======================================================================
task automatic test_reset_state();
    int err0;
    bit ok;
    err0 = errors;
    @(negedge clk);
    check_bit("mem0.stb", mem0.stb, 1'b0);
    check_bit("mem1.stb", mem1.stb, 1'b0);
    check_bit("br0_credit", br0_credit, 1'b0);
    check_bit("br1_credit", br1_credit, 1'b0);
    check_count("drop_count", drop_count, '0);
    @(posedge clk);
    // a full FIFO of words leaves on the initial credit alone
    queue_frame(0, MEM0_BASE + addr_t'(32'h40), 1'b1);
    queue_frame(0, MEM0_BASE + addr_t'(32'h80), 1'b1);
    wait_until(UNTIL_SENT, 0, 0, ok);
    take_frames(0, 2);
    // every buffered word has handed its credit back
    check_bit("br0 credits restored", (br_credits[0] == INJ_DEPTH), 1'b1);
    finish_test("reset state and initial credit", err0);
endtask

task automatic test_single_frame();
    int err0;
    int pulses0;
    err0    = errors;
    pulses0 = br_pulses[0];
    queue_frame(0, MEM0_BASE + addr_t'($urandom() & 32'h000F_FFF0), 1'b1);
    take_frames(0, 1);
    check_count("br0 credit pulses", drop_cnt_t'(br_pulses[0] - pulses0),
                drop_cnt_t'(FRAME_WORDS));
    check_bit("mem1 idle", (rx1_q.size() == 0), 1'b1);
    finish_test("single frame to mem0", err0);
endtask

task automatic test_both_branches();
    int err0;
    err0 = errors;
    for (int k = 0; k < 2; k++)
    begin
        queue_frame(0, MEM1_BASE + addr_t'($urandom() & 32'h3FFF_FFF0), 1'b1);
        queue_frame(1, MEM1_BASE + addr_t'($urandom() & 32'h3FFF_FFF0), 1'b1);
    end
    take_frames(1, 4);
    check_bit("mem0 idle", (rx0_q.size() == 0), 1'b1);
    finish_test("both branches to mem1", err0);
endtask

task automatic test_unmapped_drop();
    int        err0;
    drop_cnt_t drops0;
    bit        ok;
    err0   = errors;
    drops0 = drop_sampled;
    queue_frame(1, UNMAPPED_ADDR, 1'b0);
    wait_until(UNTIL_DROP, 0, int'(drops0) + 1, ok);
    check_count("drop_count", drop_sampled, drops0 + 8'd1);
    check_bit("mem0 idle", (rx0_q.size() == 0), 1'b1);
    check_bit("mem1 idle", (rx1_q.size() == 0), 1'b1);
    finish_test("unmapped frame dropped", err0);
endtask

task automatic test_backpressure();
    int        err0;
    drop_cnt_t drops0;
    bit        ok;
    err0   = errors;
    drops0 = drop_sampled;
    wait_until(UNTIL_OWED_CLEAR, 0, 0, ok);
    mem_hold[0] = 1'b1;
    // two frames use up the credit so the third passes and is dropped
    for (int k = 0; k < 3; k++)
    begin
        queue_frame(0, MEM0_BASE + addr_t'(k * 64), (k < 2));
    end
    take_frames(0, 2);
    wait_until(UNTIL_DROP, 0, int'(drops0) + 1, ok);
    check_count("drop_count", drop_sampled, drops0 + 8'd1);
    mem_hold[0] = 1'b0;
    wait_until(UNTIL_OWED_CLEAR, 0, 0, ok);
    queue_frame(0, MEM0_BASE + addr_t'(32'h200), 1'b1);
    take_frames(0, 1);
    check_count("drop_count", drop_sampled, drops0 + 8'd1);
    check_bit("mem0 drained", (rx0_q.size() == 0), 1'b1);
    finish_test("mem0 back-pressure", err0);
endtask

`endif

/* tb_ring_shell.sv */
// directed testbench for the slotted ring shell
// the test sequence runs on rising edges and the branch and memory models on falling edges
// a frame header carries its branch number in the top data bit
`timescale 1ns/1ps
`default_nettype none

module tb_ring_shell;
    import ring_pkg::*;

    // ======================================================================
    // timing and limits
    // ======================================================================
    localparam int CLK_NS      = 40;
    localparam int RST_CYCLES  = 16;
    localparam int SEED        = 75201;
    localparam int WAIT_CYC    = 200;
    localparam int N_TESTS     = 5;
    // no test waits more than eight times
    localparam int TEST_CYC    = 8 * WAIT_CYC;
    localparam int WATCHDOG_NS = (RST_CYCLES + N_TESTS * TEST_CYC + 100) * CLK_NS;

    // above MEM1_LAST and so outside both spaces
    localparam addr_t UNMAPPED_ADDR = 39'h10_0000_0000;

    logic      clk = 1'b0;
    logic      rst = 1'b1;
    stream_t   br0 = '0;
    stream_t   br1 = '0;
    logic      br0_credit;
    logic      br1_credit;
    stream_t   mem0;
    stream_t   mem1;
    logic      mem0_credit = 1'b0;
    logic      mem1_credit = 1'b0;
    drop_cnt_t drop_count;

    // branch side
    stream_t   br0_q [$];
    stream_t   br1_q [$];
    int        br_credits [2] = '{INJ_DEPTH, INJ_DEPTH};
    int        br_pulses [2]  = '{0, 0};

    // memory side with expected words kept per branch
    stream_t   rx0_q [$];
    stream_t   rx1_q [$];
    word_t     exp_br0_q [$];
    word_t     exp_br1_q [$];
    int        mem_owed [2]  = '{0, 0};
    logic      mem_hold [2]  = '{1'b0, 1'b0};
    drop_cnt_t drop_sampled  = '0;

    int        errors       = 0;
    int        checks       = 0;
    int        tests_run    = 0;
    int        tests_failed = 0;
    int        seed_val;

    always #(CLK_NS / 2) clk = ~clk;

    ring_shell i_ring_shell
    (
        .clk           (clk),
        .rst           (rst),
        .i_br0         (br0),
        .i_br1         (br1),
        .o_br0_credit  (br0_credit),
        .o_br1_credit  (br1_credit),
        .o_mem0        (mem0),
        .o_mem1        (mem1),
        .i_mem0_credit (mem0_credit),
        .i_mem1_credit (mem1_credit),
        .o_drop_count  (drop_count)
    );

    // ======================================================================
    // branch models
    // ======================================================================
    // one credit spent per word and one regained per pulse
    always @(negedge clk)
    begin
        if (br0_credit)
        begin
            br_credits[0] += 1;
            br_pulses[0]  += 1;
        end
        if (br0_q.size() > 0 && br_credits[0] > 0)
        begin
            br0 = br0_q.pop_front();
            br_credits[0] -= 1;
        end
        else
            br0 = '0;
    end

    always @(negedge clk)
    begin
        if (br1_credit)
        begin
            br_credits[1] += 1;
            br_pulses[1]  += 1;
        end
        if (br1_q.size() > 0 && br_credits[1] > 0)
        begin
            br1 = br1_q.pop_front();
            br_credits[1] -= 1;
        end
        else
            br1 = '0;
    end

    // ======================================================================
    // memory models
    // ======================================================================
    // record every word and hand back one credit per word unless held
    always @(negedge clk)
    begin
        drop_sampled = drop_count;
        if (mem0.stb)
        begin
            rx0_q.push_back(mem0);
            mem_owed[0] += 1;
        end
        if (!mem_hold[0] && mem_owed[0] > 0)
        begin
            mem0_credit = 1'b1;
            mem_owed[0] -= 1;
        end
        else
            mem0_credit = 1'b0;

        if (mem1.stb)
        begin
            rx1_q.push_back(mem1);
            mem_owed[1] += 1;
        end
        if (!mem_hold[1] && mem_owed[1] > 0)
        begin
            mem1_credit = 1'b1;
            mem_owed[1] -= 1;
        end
        else
            mem1_credit = 1'b0;
    end

    `include "tb_ring_tasks.svh"

    // ======================================================================
    // test sequence
    // ======================================================================
    initial
    begin
        seed_val = $urandom(SEED);
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);

        test_reset_state();
        test_single_frame();
        test_both_branches();
        test_unmapped_drop();
        test_backpressure();

        $display("summary: %0d tests run, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, test sequence did not complete", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

/* ring_shell.sv */
// ring shell top: slot generator, two branch injectors, two memory extractors, sink
// branch 0 sits upstream of branch 1 and wins a shared free slot
// frames that no extractor takes, including for lack of credit, are dropped at the sink
`timescale 1ns/1ps
`default_nettype none

module ring_shell
(
    input  wire                  clk,
    input  wire                  rst,

    // branch inputs
    input  ring_pkg::stream_t    i_br0,
    input  ring_pkg::stream_t    i_br1,
    output logic                 o_br0_credit,
    output logic                 o_br1_credit,

    // memory ports
    output ring_pkg::stream_t    o_mem0,
    output ring_pkg::stream_t    o_mem1,
    input  wire                  i_mem0_credit,
    input  wire                  i_mem1_credit,

    output ring_pkg::drop_cnt_t  o_drop_count
);
    import ring_pkg::*;

    // ring segments, head to tail
    slot_t slot_gen_out;
    slot_t slot_inj0_out;
    slot_t slot_inj1_out;
    slot_t slot_ext0_out;
    slot_t slot_ext1_out;

    // ======================================================================
    // head and branch injectors
    // ======================================================================
    ring_slot_gen u_slot_gen
    (
        .clk         (clk),
        .rst         (rst),
        .o_slot      (slot_gen_out)
    );

    ring_injector u_inj0
    (
        .clk         (clk),
        .rst         (rst),
        .i_slot      (slot_gen_out),
        .o_slot      (slot_inj0_out),
        .i_br        (i_br0),
        .o_br_credit (o_br0_credit)
    );

    ring_injector u_inj1
    (
        .clk         (clk),
        .rst         (rst),
        .i_slot      (slot_inj0_out),
        .o_slot      (slot_inj1_out),
        .i_br        (i_br1),
        .o_br_credit (o_br1_credit)
    );

    // ======================================================================
    // memory extractors and tail
    // ======================================================================
    // boot ROM
    ring_extractor #(
        .SPACE_BASE  (MEM0_BASE),
        .SPACE_LAST  (MEM0_LAST)
    ) u_ext0 (
        .clk         (clk),
        .rst         (rst),
        .i_slot      (slot_inj1_out),
        .o_slot      (slot_ext0_out),
        .o_port      (o_mem0),
        .i_credit    (i_mem0_credit)
    );

    // external RAM
    ring_extractor #(
        .SPACE_BASE  (MEM1_BASE),
        .SPACE_LAST  (MEM1_LAST)
    ) u_ext1 (
        .clk         (clk),
        .rst         (rst),
        .i_slot      (slot_ext0_out),
        .o_slot      (slot_ext1_out),
        .o_port      (o_mem1),
        .i_credit    (i_mem1_credit)
    );

    ring_sink u_sink
    (
        .clk          (clk),
        .rst          (rst),
        .i_slot       (slot_ext1_out),
        .o_drop_count (o_drop_count)
    );

endmodule

`default_nettype wire

/* ring_sink.sv */
// tail of the ring: every slot ends here, a busy one means nobody claimed it
// the drop count saturates and only clears on reset
`timescale 1ns/1ps
`default_nettype none

module ring_sink
(
    input  wire                  clk,
    input  wire                  rst,
    input  ring_pkg::slot_t      i_slot,
    output ring_pkg::drop_cnt_t  o_drop_count
);
    import ring_pkg::*;

    drop_cnt_t drop_cnt;
    logic      dropped;

    // one count per unclaimed frame, taken at its slot start
    assign dropped = i_slot.sof && i_slot.busy;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
            drop_cnt <= '0;
        else if (dropped && (drop_cnt != '1))
            drop_cnt <= drop_cnt + 1'b1;
    end

    assign o_drop_count = drop_cnt;

    // upstream stages set and clear busy for a whole slot at a time
    a_busy_per_slot : assert property (
        @(posedge clk) disable iff (rst)
        !i_slot.sof |-> (i_slot.busy == $past(i_slot.busy))
    );

endmodule

`default_nettype wire

/* ring_extractor.sv */
// address-space extractor: takes busy slots whose header falls in its space
// claims only with a whole frame of memory credits in hand, else the slot passes on
// header address is the low ADDR_W bits of the first word
`timescale 1ns/1ps
`default_nettype none

module ring_extractor
#(
    parameter ring_pkg::addr_t SPACE_BASE = '0,
    parameter ring_pkg::addr_t SPACE_LAST = '1
)
(
    input  wire                clk,
    input  wire                rst,
    input  ring_pkg::slot_t    i_slot,
    output ring_pkg::slot_t    o_slot,
    output ring_pkg::stream_t  o_port,
    input  wire                i_credit
);
    import ring_pkg::*;

    ext_state_t             state;
    logic [FRAME_CNT_W-1:0] word_cnt;
    logic [MEM_CRED_W-1:0]  cred_cnt;

    addr_t                  hdr_addr;
    logic                   in_space;
    logic                   claim_start;
    logic                   send;

    logic                   slot_sof;
    logic                   slot_busy;
    word_t                  slot_data;
    logic                   port_stb;
    logic                   port_sof;
    word_t                  port_data;

    // ======================================================================
    // claim decision
    // ======================================================================
    assign hdr_addr    = i_slot.data[ADDR_W-1:0];
    assign in_space    = (hdr_addr >= SPACE_BASE) && (hdr_addr <= SPACE_LAST);
    assign claim_start = (state == EXT_PASS) && i_slot.sof && i_slot.busy && in_space
                         && (cred_cnt >= MEM_CRED_W'(FRAME_WORDS));
    assign send        = claim_start || (state == EXT_CLAIM);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state     <= EXT_PASS;
            word_cnt  <= '0;
            cred_cnt  <= MEM_CRED_W'(MEM_CREDITS);
            slot_sof  <= 1'b0;
            slot_busy <= 1'b0;
            port_stb  <= 1'b0;
            port_sof  <= 1'b0;
        end
        else
        begin
            slot_sof  <= i_slot.sof;
            // claimed words leave the ring as free slot space
            slot_busy <= i_slot.busy & ~send;
            port_stb  <= send;
            port_sof  <= claim_start;
            cred_cnt  <= cred_cnt - MEM_CRED_W'(send) + MEM_CRED_W'(i_credit);

            if (send)
                word_cnt <= word_cnt + 1'b1;

            case (state)
                EXT_PASS:
                begin
                    if (claim_start)
                        state <= EXT_CLAIM;
                end
                EXT_CLAIM:
                begin
                    if (word_cnt == FRAME_CNT_W'(FRAME_WORDS - 1))
                        state <= EXT_PASS;
                end
                default:
                    state <= EXT_PASS;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        slot_data <= i_slot.data;
        port_data <= i_slot.data;
    end

    assign o_slot = '{sof: slot_sof, busy: slot_busy, data: slot_data};
    assign o_port = '{stb: port_stb, sof: port_sof, data: port_data};

    // memory never hands back more than it was given
    a_credit_max : assert property (
        @(posedge clk) disable iff (rst) cred_cnt <= MEM_CRED_W'(MEM_CREDITS)
    );

    a_credit_held : assert property (
        @(posedge clk) disable iff (rst) send |-> (cred_cnt != '0)
    );

endmodule

`default_nettype wire

/* ring_injector.sv */
// branch injector: buffers branch words and drops a whole frame into a free slot
// the branch must follow credit flow, starting with INJ_DEPTH credits
// a frame is only placed once all FRAME_WORDS words are buffered
`timescale 1ns/1ps
`default_nettype none

module ring_injector
(
    input  wire               clk,
    input  wire               rst,
    input  ring_pkg::slot_t   i_slot,
    output ring_pkg::slot_t   o_slot,
    input  ring_pkg::stream_t i_br,
    output logic              o_br_credit
);
    import ring_pkg::*;

    // ======================================================================
    // input FIFO
    // ======================================================================
    word_t                  fifo_mem [INJ_DEPTH];
    logic [INJ_PTR_W-1:0]   wr_ptr;
    logic [INJ_PTR_W-1:0]   rd_ptr;
    logic [INJ_PTR_W-1:0]   fifo_count;
    logic                   fifo_full;
    logic                   frame_ready;

    inj_state_t             state;
    logic [FRAME_CNT_W-1:0] emit_cnt;
    logic [FRAME_CNT_W-1:0] in_pos;
    logic                   take;
    logic                   rd_en;

    logic                   slot_sof;
    logic                   slot_busy;
    word_t                  slot_data;

    assign fifo_count  = wr_ptr - rd_ptr;
    assign fifo_full   = (fifo_count == INJ_PTR_W'(INJ_DEPTH));
    assign frame_ready = (fifo_count >= INJ_PTR_W'(FRAME_WORDS));

    always_ff @(posedge clk)
    begin
        if (i_br.stb)
            fifo_mem[wr_ptr[INJ_PTR_W-2:0]] <= i_br.data;
    end

    // ======================================================================
    // slot capture
    // ======================================================================
    // grab the first empty slot start once a frame is waiting
    assign take  = (state != INJ_EMIT) && frame_ready && i_slot.sof && !i_slot.busy;
    assign rd_en = take || (state == INJ_EMIT);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state       <= INJ_FILL;
            emit_cnt    <= '0;
            in_pos      <= '0;
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            slot_sof    <= 1'b0;
            slot_busy   <= 1'b0;
            o_br_credit <= 1'b0;
        end
        else
        begin
            slot_sof    <= i_slot.sof;
            slot_busy   <= i_slot.busy | rd_en;
            o_br_credit <= rd_en;

            if (i_br.stb)
            begin
                wr_ptr <= wr_ptr + 1'b1;
                in_pos <= in_pos + 1'b1;
            end

            if (rd_en)
            begin
                rd_ptr   <= rd_ptr + 1'b1;
                emit_cnt <= emit_cnt + 1'b1;
            end

            case (state)
                INJ_FILL:
                begin
                    if (take)
                        state <= INJ_EMIT;
                    else if (frame_ready)
                        state <= INJ_WAIT_SLOT;
                end
                INJ_WAIT_SLOT:
                begin
                    if (take)
                        state <= INJ_EMIT;
                end
                INJ_EMIT:
                begin
                    // last word of the frame goes out this cycle
                    if (emit_cnt == FRAME_CNT_W'(FRAME_WORDS - 1))
                        state <= INJ_FILL;
                end
                default:
                    state <= INJ_FILL;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        slot_data <= rd_en ? fifo_mem[rd_ptr[INJ_PTR_W-2:0]] : i_slot.data;
    end

    assign o_slot = '{sof: slot_sof, busy: slot_busy, data: slot_data};

    // credit flow on the branch keeps the FIFO from overflowing
    a_no_overflow : assert property (
        @(posedge clk) disable iff (rst) !(i_br.stb && fifo_full)
    );

    // branch frames are FRAME_WORDS long, sof only on the first
    a_frame_align : assert property (
        @(posedge clk) disable iff (rst) i_br.stb |-> (i_br.sof == (in_pos == '0))
    );

endmodule

`default_nettype wire

/* ring_slot_gen.sv */
// head of the ring: emits empty slots back to back, one every FRAME_WORDS cycles
// the first slot starts on the first clock after reset is released
`timescale 1ns/1ps
`default_nettype none

module ring_slot_gen
(
    input  wire              clk,
    input  wire              rst,
    output ring_pkg::slot_t  o_slot
);
    import ring_pkg::*;

    logic [FRAME_CNT_W-1:0] word_cnt;
    logic                   sof_q;

    // word position inside the current slot
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            word_cnt <= '0;
            sof_q    <= 1'b0;
        end
        else
        begin
            word_cnt <= word_cnt + 1'b1;
            sof_q    <= (word_cnt == '0);
        end
    end

    // slots leave empty
    assign o_slot = '{sof: sof_q, busy: 1'b0, data: '0};

    // slot starts keep a fixed period once the ring has run a full slot
    a_sof_period : assert property (
        @(posedge clk) disable iff (rst)
        !$past(rst, FRAME_WORDS) |-> (o_slot.sof == $past(o_slot.sof, FRAME_WORDS))
    );

endmodule

`default_nettype wire

/* ring_pkg.sv */
// shared widths, address spaces and bus types of the slotted ring
// INJ_DEPTH and FRAME_WORDS must be powers of two, since the pointers wrap freely
// address spaces must not overlap; a frame goes to the first extractor that matches
`default_nettype none

package ring_pkg;

    // ======================================================================
    // widths and constants
    // ======================================================================
    localparam int WORD_W      = 72;
    localparam int ADDR_W      = 39;
    localparam int FRAME_WORDS = 4;
    localparam int INJ_DEPTH   = 8;
    localparam int MEM_CREDITS = 8;
    localparam int CNT_W       = 8;

    // derived counter widths
    localparam int FRAME_CNT_W = $clog2(FRAME_WORDS);
    localparam int INJ_PTR_W   = $clog2(INJ_DEPTH) + 1;
    localparam int MEM_CRED_W  = $clog2(MEM_CREDITS + 1);

    // boot ROM, 1 MiB at the bottom
    localparam logic [ADDR_W-1:0] MEM0_BASE = 39'h00_0000_0000;
    localparam logic [ADDR_W-1:0] MEM0_LAST = 39'h00_000F_FFFF;

    // external RAM, 1 GiB window
    localparam logic [ADDR_W-1:0] MEM1_BASE = 39'h00_4000_0000;
    localparam logic [ADDR_W-1:0] MEM1_LAST = 39'h00_7FFF_FFFF;

    // ======================================================================
    // types
    // ======================================================================
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [CNT_W-1:0]  drop_cnt_t;

    // one ring word position, sof marks the first word of a slot
    typedef struct packed {
        logic  sof;
        logic  busy;
        word_t data;
    } slot_t;

    // branch and memory side stream
    typedef struct packed {
        logic  stb;
        logic  sof;
        word_t data;
    } stream_t;

    typedef enum logic [1:0] {
        INJ_FILL,
        INJ_WAIT_SLOT,
        INJ_EMIT
    } inj_state_t;

    typedef enum logic {
        EXT_PASS,
        EXT_CLAIM
    } ext_state_t;

endpackage

`default_nettype wire
